// File: Bender.yml
package:
  name: accum_bank

sources:
  - accum_pkg.sv
  - accum_bank_if.sv
  - accum_apb_regs.sv
  - accum_ctrl_fsm.sv
  - accum_bank.sv
  - accum_normquant.sv
  - accum_top.sv
  - target: test
    files:
      - accum_asserts.sv
      - tb_accum.sv

// File: accum_apb_regs.sv
// APB configuration and command registers
`timescale 1ns/1ps

module accum_apb_regs #(
  parameter int unsigned NumAcc = accum_pkg::NUM_ACC
) (
  input  logic                        clk_state,
  input  logic                        rst_ni,
  input  logic                        psel_i,
  input  logic                        penable_i,
  input  logic                        pwrite_i,
  input  logic [7:0]                  paddr_i,
  input  logic [31:0]                 pwdata_i,
  input  logic                        busy_i,
  output logic [31:0]                 prdata_o,
  output logic                        pready_o,
  output logic                        pslverr_o,
  output logic                        cmd_valid_o,
  output logic [2:0]                  cmd_code_o,
  output logic [accum_pkg::LEN_W-1:0] accum_len_o,
  output logic [7:0]                  scale_o,
  output logic [4:0]                  shift_o,
  output logic                        mode_o
);

  logic access;
  logic wr_access;
  logic addr_ok;
  logic cmd_wr;
  logic cmd_known;

  assign access    = psel_i & penable_i;
  assign wr_access = access & pwrite_i;
  assign pready_o  = 1'b1;  // zero wait states

  // ============================================================
  // address decode and read mux
  // ============================================================
  always_comb begin
    addr_ok  = 1'b1;
    prdata_o = '0;
    case (paddr_i)
      accum_pkg::REG_CMD:       prdata_o = '0;  // write-only
      accum_pkg::REG_ACCUM_LEN: prdata_o = 32'(accum_len_o);
      accum_pkg::REG_SCALE:     prdata_o = 32'(scale_o);
      accum_pkg::REG_SHIFT:     prdata_o = 32'(shift_o);
      accum_pkg::REG_MODE:      prdata_o = 32'(mode_o);
      accum_pkg::REG_STATUS:    prdata_o = {16'h0, 8'(NumAcc), 7'h0, busy_i};
      default:                  addr_ok  = 1'b0;
    endcase
  end

  // command launch
  assign cmd_wr     = wr_access & (paddr_i == accum_pkg::REG_CMD);
  assign cmd_known  = pwdata_i[2:0] inside {accum_pkg::CMD_CLEAR, accum_pkg::CMD_ACCUM,
                                            accum_pkg::CMD_NORMQUANT, accum_pkg::CMD_STREAMOUT};
  assign cmd_valid_o = cmd_wr & ~busy_i & cmd_known;
  assign cmd_code_o  = pwdata_i[2:0];

  // unmapped address, or a command that cannot be taken
  assign pslverr_o = access & (~addr_ok | (cmd_wr & (busy_i | ~cmd_known)));

  // ============================================================
  // held configuration
  // ============================================================
  always_ff @(posedge clk_state or negedge rst_ni) begin
    if (!rst_ni) begin
      accum_len_o <= '0;
      scale_o     <= '0;
      shift_o     <= '0;
      mode_o      <= accum_pkg::MODE_8B;
    end else if (wr_access) begin
      case (paddr_i)
        accum_pkg::REG_ACCUM_LEN: accum_len_o <= pwdata_i[accum_pkg::LEN_W-1:0];
        accum_pkg::REG_SCALE:     scale_o     <= pwdata_i[7:0];
        accum_pkg::REG_SHIFT:     shift_o     <= pwdata_i[4:0];
        accum_pkg::REG_MODE:      mode_o      <= pwdata_i[0];
        default: ;  // CMD and STATUS hold nothing here
      endcase
    end
  end

endmodule

// File: accum_asserts.sv
// Accumulator bank protocol assertions
`timescale 1ns/1ps

module accum_asserts (
  input logic        clk_state,
  input logic        rst_ni,
  input logic        psel_i,
  input logic        pready_o,
  input logic        psum_ready_o,
  input logic        out_valid_o,
  input logic        out_ready_i,
  input logic [63:0] out_data_o,
  input logic        done_o
);

  int unsigned fail_cnt = 0;  // failed assertions so far

  // the two streams belong to different states
  a_streams_excl: assert property (@(posedge clk_state) disable iff (!rst_ni)
    !(psum_ready_o && out_valid_o)) else begin
    $error("psum_ready_o and out_valid_o high together");
    fail_cnt++;
  end

  a_out_hold: assert property (@(posedge clk_state) disable iff (!rst_ni)
    out_valid_o && !out_ready_i |=> out_valid_o && $stable(out_data_o)) else begin
    $error("output word changed under back-pressure");
    fail_cnt++;
  end

  a_done_pulse: assert property (@(posedge clk_state) disable iff (!rst_ni)
    done_o |=> !done_o) else begin
    $error("done_o longer than one cycle");
    fail_cnt++;
  end

  a_pready: assert property (@(posedge clk_state) disable iff (!rst_ni)
    psel_i |-> pready_o) else begin
    $error("pready_o low during an APB access");
    fail_cnt++;
  end

endmodule

bind accum_top accum_asserts i_accum_asserts (
  .clk_state    ( clk_state    ),
  .rst_ni       ( rst_ni       ),
  .psel_i       ( psel_i       ),
  .pready_o     ( pready_o     ),
  .psum_ready_o ( psum_ready_o ),
  .out_valid_o  ( out_valid_o  ),
  .out_ready_i  ( out_ready_i  ),
  .out_data_o   ( out_data_o   ),
  .done_o       ( done_o       )
);

// File: accum_bank.sv
// Accumulator register bank
`timescale 1ns/1ps

module accum_bank #(
  parameter int unsigned NumAcc = accum_pkg::NUM_ACC
) (
  input  logic       clk_state,
  input  logic       rst_ni,
  accum_bank_if.bank bank_if
);

  logic [NumAcc-1:0][accum_pkg::ACC_W-1:0] acc_q;
  logic signed [accum_pkg::ACC_W-1:0]      sum;

  // ============================================================
  // adder, wraps on overflow
  // ============================================================
  assign sum = $signed(acc_q[bank_if.add_addr]) + bank_if.psum;

  always_ff @(posedge clk_state or negedge rst_ni) begin
    if (!rst_ni) begin
      acc_q <= '0;
    end else if (bank_if.clear) begin
      acc_q <= '0;  // whole bank in one cycle
    end else begin
      if (bank_if.wr_en) begin
        acc_q[bank_if.wr_addr] <= bank_if.wr_data;  // normquant write-back
      end
      if (bank_if.add_en) begin
        acc_q[bank_if.add_addr] <= sum;
      end
    end
  end

  // combinational read ports
  assign bank_if.rd_data = acc_q[bank_if.rd_addr];
  assign bank_if.acc_all = acc_q;

endmodule

// File: accum_bank_if.sv
// Accumulator bank access interface
`timescale 1ns/1ps

interface accum_bank_if #(
  parameter int unsigned NumAcc = accum_pkg::NUM_ACC
);

  // accumulate and clear, from the FSM
  logic                                 clear;
  logic                                 add_en;
  logic [accum_pkg::ADDR_W-1:0]         add_addr;
  logic signed [accum_pkg::ACC_W-1:0]   psum;

  // read side
  logic [accum_pkg::ADDR_W-1:0]         rd_addr;
  logic signed [accum_pkg::ACC_W-1:0]   rd_data;
  logic [NumAcc-1:0][accum_pkg::ACC_W-1:0] acc_all;  // whole bank, for streamout packing

  // normquant issue and write-back
  logic                                 nq_valid;
  logic [accum_pkg::ADDR_W-1:0]         nq_addr;
  logic                                 wr_en;
  logic [accum_pkg::ADDR_W-1:0]         wr_addr;
  logic [accum_pkg::ACC_W-1:0]          wr_data;

  modport ctrl (output clear, add_en, add_addr, psum, rd_addr, nq_valid, nq_addr,
                input  acc_all);
  modport bank (input  clear, add_en, add_addr, psum, rd_addr, wr_en, wr_addr, wr_data,
                output rd_data, acc_all);
  modport nq   (input  rd_data, nq_valid, nq_addr,
                output wr_en, wr_addr, wr_data);

endinterface

// File: accum_ctrl_fsm.sv
// Command state machine and streamout packing
`timescale 1ns/1ps

module accum_ctrl_fsm #(
  parameter int unsigned NumAcc = accum_pkg::NUM_ACC
) (
  input  logic                        clk_state,
  input  logic                        rst_ni,
  input  logic                        cmd_valid_i,
  input  logic [2:0]                  cmd_code_i,
  input  logic [accum_pkg::LEN_W-1:0] accum_len_i,
  input  logic                        mode_i,
  input  logic                        psum_valid_i,
  input  logic [accum_pkg::ACC_W-1:0] psum_data_i,
  input  logic                        out_ready_i,
  output logic                        busy_o,
  output logic                        psum_ready_o,
  output logic                        out_valid_o,
  output logic [accum_pkg::OUT_W-1:0] out_data_o,
  output logic                        done_o,
  accum_bank_if.ctrl                  bank_if
);

  localparam logic [2:0] IDLE      = 3'd0;
  localparam logic [2:0] CLEAR     = 3'd1;
  localparam logic [2:0] ACCUM     = 3'd2;
  localparam logic [2:0] NORMQUANT = 3'd3;
  localparam logic [2:0] NQ_DRAIN  = 3'd4;
  localparam logic [2:0] STREAMOUT = 3'd5;

  logic [2:0]                  state_q, state_d;
  logic [accum_pkg::ADDR_W-1:0] cnt_q, cnt_d, cnt_inc;
  logic [accum_pkg::LEN_W-1:0]  len_cnt_q, len_cnt_d;
  logic                        done_d;
  logic                        psum_hs, out_hs, last_beat;
  accum_pkg::out_word_u        out_word;

  assign psum_hs   = psum_valid_i & psum_ready_o;
  assign out_hs    = out_valid_o & out_ready_i;
  assign cnt_inc   = (int'(cnt_q) == NumAcc - 1) ? '0 : cnt_q + 1'b1;  // wraps mod NumAcc
  assign last_beat = (mode_i == accum_pkg::MODE_8B) || (int'(cnt_q) == NumAcc/2 - 1);

  // ============================================================
  // next state
  // ============================================================
  always_comb begin
    state_d   = state_q;
    cnt_d     = cnt_q;
    len_cnt_d = len_cnt_q;
    done_d    = 1'b0;
    case (state_q)
      IDLE: if (cmd_valid_i) begin
        cnt_d     = '0;
        len_cnt_d = '0;
        case (cmd_code_i)
          accum_pkg::CMD_CLEAR:     state_d = CLEAR;
          accum_pkg::CMD_NORMQUANT: state_d = NORMQUANT;
          accum_pkg::CMD_STREAMOUT: state_d = STREAMOUT;
          accum_pkg::CMD_ACCUM: begin
            if (accum_len_i == '0) done_d = 1'b1;  // nothing to add
            else state_d = ACCUM;
          end
          default: ;
        endcase
      end
      CLEAR: begin
        state_d = IDLE;
        done_d  = 1'b1;
      end
      ACCUM: if (psum_hs) begin
        cnt_d     = cnt_inc;
        len_cnt_d = len_cnt_q + 1'b1;
        if (len_cnt_q == accum_len_i - 1'b1) begin
          state_d = IDLE;
          done_d  = 1'b1;
        end
      end
      NORMQUANT: begin
        cnt_d = cnt_inc;
        if (int'(cnt_q) == NumAcc - 1) state_d = NQ_DRAIN;
      end
      NQ_DRAIN: begin  // two results still in the pipeline
        cnt_d = cnt_inc;
        if (cnt_q == 1) begin
          state_d = IDLE;
          done_d  = 1'b1;
        end
      end
      STREAMOUT: if (out_hs) begin
        cnt_d = cnt_inc;
        if (last_beat) begin
          state_d = IDLE;
          done_d  = 1'b1;
        end
      end
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk_state or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q   <= IDLE;
      cnt_q     <= '0;
      len_cnt_q <= '0;
      done_o    <= 1'b0;
    end else begin
      state_q   <= state_d;
      cnt_q     <= cnt_d;
      len_cnt_q <= len_cnt_d;
      done_o    <= done_d;
    end
  end

  assign busy_o       = (state_q != IDLE);
  assign psum_ready_o = (state_q == ACCUM);
  assign out_valid_o  = (state_q == STREAMOUT);

  // bank side
  assign bank_if.clear    = (state_q == CLEAR);
  assign bank_if.add_en   = psum_hs;
  assign bank_if.add_addr = cnt_q;
  assign bank_if.psum     = psum_data_i;
  assign bank_if.rd_addr  = cnt_q;
  assign bank_if.nq_valid = (state_q == NORMQUANT);
  assign bank_if.nq_addr  = cnt_q;

  // ============================================================
  // streamout packing
  // ============================================================
  always_comb begin
    out_word = '0;
    if (mode_i == accum_pkg::MODE_32B) begin
      out_word.words[0] = bank_if.acc_all[{cnt_q[accum_pkg::ADDR_W-2:0], 1'b0}];
      out_word.words[1] = bank_if.acc_all[{cnt_q[accum_pkg::ADDR_W-2:0], 1'b1}];
    end else begin
      for (int i = 0; i < accum_pkg::OUT_W/8; i++) begin
        out_word.bytes[i] = bank_if.acc_all[i][7:0];  // low byte holds the quantized value
      end
    end
  end

  assign out_data_o = out_word;

endmodule

// File: accum_normquant.sv
// Scale, shift and clip pipeline
`timescale 1ns/1ps

module accum_normquant #(
  parameter int unsigned NumAcc = accum_pkg::NUM_ACC
) (
  input  logic       clk_state,
  input  logic       rst_ni,
  input  logic [7:0] scale_i,
  input  logic [4:0] shift_i,
  accum_bank_if.nq   bank_if
);

  logic signed [39:0]           prod_d, prod_q;
  logic signed [39:0]           shifted;
  logic [7:0]                   clip;
  logic                         valid_q, wr_en_q;
  logic [accum_pkg::ADDR_W-1:0] addr_q, wr_addr_q;
  logic [7:0]                   wr_byte_q;

  // ============================================================
  // stage 1, multiply by the unsigned scale
  // ============================================================
  assign prod_d = $signed(bank_if.rd_data) * $signed({1'b0, scale_i});

  // stage 2, arithmetic shift and saturate to int8
  assign shifted = prod_q >>> shift_i;
  assign clip    = (shifted > 40'sd127)  ? 8'h7f :
                   (shifted < -40'sd128) ? 8'h80 : shifted[7:0];

  always_ff @(posedge clk_state or negedge rst_ni) begin
    if (!rst_ni) begin
      prod_q    <= '0;
      valid_q   <= 1'b0;
      addr_q    <= '0;
      wr_en_q   <= 1'b0;
      wr_addr_q <= '0;
      wr_byte_q <= '0;
    end else begin
      prod_q    <= prod_d;
      valid_q   <= bank_if.nq_valid;
      addr_q    <= bank_if.nq_addr;
      wr_en_q   <= valid_q;
      wr_addr_q <= addr_q;
      wr_byte_q <= clip;
    end
  end

  // write-back two cycles after the read
  assign bank_if.wr_en   = wr_en_q;
  assign bank_if.wr_addr = wr_addr_q;
  assign bank_if.wr_data = {{(accum_pkg::ACC_W-8){wr_byte_q[7]}}, wr_byte_q};

endmodule

// File: accum_pkg.sv
// Accumulator bank shared definitions
package accum_pkg;

  // ============================================================
  // sizes
  // ============================================================
  localparam int unsigned NUM_ACC = 8;   // accumulators in the bank
  localparam int unsigned ACC_W   = 32;
  localparam int unsigned OUT_W   = 64;  // output stream word
  localparam int unsigned ADDR_W  = 3;
  localparam int unsigned LEN_W   = 16;  // accumulation length

  // ============================================================
  // APB register map, byte offsets
  // ============================================================
  localparam logic [7:0] REG_CMD       = 8'h00;
  localparam logic [7:0] REG_ACCUM_LEN = 8'h04;
  localparam logic [7:0] REG_SCALE     = 8'h08;
  localparam logic [7:0] REG_SHIFT     = 8'h0C;
  localparam logic [7:0] REG_MODE      = 8'h10;
  localparam logic [7:0] REG_STATUS    = 8'h14;

  // command codes, zero is not a command
  localparam logic [2:0] CMD_CLEAR     = 3'd1;
  localparam logic [2:0] CMD_ACCUM     = 3'd2;
  localparam logic [2:0] CMD_NORMQUANT = 3'd3;
  localparam logic [2:0] CMD_STREAMOUT = 3'd4;

  // streamout packing
  localparam logic MODE_8B  = 1'b0;
  localparam logic MODE_32B = 1'b1;

  // one output beat: eight quantized bytes or two raw accumulators
  typedef union packed {
    logic [OUT_W/8-1:0][7:0]           bytes;
    logic [OUT_W/ACC_W-1:0][ACC_W-1:0] words;
  } out_word_u;

endpackage

// File: accum_top.sv
// Accumulator bank top level
`timescale 1ns/1ps

module accum_top #(
  parameter int unsigned NumAcc = accum_pkg::NUM_ACC
) (
  input  logic                        clk_state,
  input  logic                        rst_ni,
  // APB
  input  logic                        psel_i,
  input  logic                        penable_i,
  input  logic                        pwrite_i,
  input  logic [7:0]                  paddr_i,
  input  logic [31:0]                 pwdata_i,
  output logic [31:0]                 prdata_o,
  output logic                        pready_o,
  output logic                        pslverr_o,
  // partial sums in
  input  logic                        psum_valid_i,
  output logic                        psum_ready_o,
  input  logic [accum_pkg::ACC_W-1:0] psum_data_i,
  // results out
  output logic                        out_valid_o,
  input  logic                        out_ready_i,
  output logic [accum_pkg::OUT_W-1:0] out_data_o,
  output logic                        done_o
);

  logic                        busy;
  logic                        cmd_valid;
  logic [2:0]                  cmd_code;
  logic [accum_pkg::LEN_W-1:0] accum_len;
  logic [7:0]                  scale;
  logic [4:0]                  shift;
  logic                        mode;

  accum_bank_if #(.NumAcc(NumAcc)) bank_if ();

  accum_apb_regs #(.NumAcc(NumAcc)) i_apb_regs (
    .clk_state   ( clk_state ),
    .rst_ni      ( rst_ni    ),
    .psel_i      ( psel_i    ),
    .penable_i   ( penable_i ),
    .pwrite_i    ( pwrite_i  ),
    .paddr_i     ( paddr_i   ),
    .pwdata_i    ( pwdata_i  ),
    .busy_i      ( busy      ),
    .prdata_o    ( prdata_o  ),
    .pready_o    ( pready_o  ),
    .pslverr_o   ( pslverr_o ),
    .cmd_valid_o ( cmd_valid ),
    .cmd_code_o  ( cmd_code  ),
    .accum_len_o ( accum_len ),
    .scale_o     ( scale     ),
    .shift_o     ( shift     ),
    .mode_o      ( mode      )
  );

  accum_ctrl_fsm #(.NumAcc(NumAcc)) i_ctrl_fsm (
    .clk_state    ( clk_state    ),
    .rst_ni       ( rst_ni       ),
    .cmd_valid_i  ( cmd_valid    ),
    .cmd_code_i   ( cmd_code     ),
    .accum_len_i  ( accum_len    ),
    .mode_i       ( mode         ),
    .psum_valid_i ( psum_valid_i ),
    .psum_data_i  ( psum_data_i  ),
    .out_ready_i  ( out_ready_i  ),
    .busy_o       ( busy         ),
    .psum_ready_o ( psum_ready_o ),
    .out_valid_o  ( out_valid_o  ),
    .out_data_o   ( out_data_o   ),
    .done_o       ( done_o       ),
    .bank_if      ( bank_if.ctrl )
  );

  accum_bank #(.NumAcc(NumAcc)) i_bank (
    .clk_state ( clk_state    ),
    .rst_ni    ( rst_ni       ),
    .bank_if   ( bank_if.bank )
  );

  accum_normquant #(.NumAcc(NumAcc)) i_normquant (
    .clk_state ( clk_state  ),
    .rst_ni    ( rst_ni     ),
    .scale_i   ( scale      ),
    .shift_i   ( shift      ),
    .bank_if   ( bank_if.nq )
  );

endmodule

// File: all.f
accum_pkg.sv
accum_bank_if.sv
accum_apb_regs.sv
accum_ctrl_fsm.sv
accum_bank.sv
accum_normquant.sv
accum_top.sv
accum_asserts.sv
tb_accum.sv

// File: tb_accum.sv
// Accumulator bank testbench
`timescale 1ns/1ps

module tb_accum;

  localparam int NumTests  = 6;
  localparam int NumPsums  = 44;  // 8 + 20 + 12 + 4
  localparam time TimeLimit = (NumTests * 200 + NumPsums * 8) * 8;

  logic        clk_state, rst_ni;
  logic        psel_i, penable_i, pwrite_i;
  logic [7:0]  paddr_i;
  logic [31:0] pwdata_i, prdata_o;
  logic        pready_o, pslverr_o;
  logic        psum_valid_i, psum_ready_o;
  logic [31:0] psum_data_i;
  logic        out_valid_o, out_ready_i;
  logic [63:0] out_data_o;
  logic        done_o;

  logic [31:0] ref_acc [8];  // reference model of the bank
  logic [31:0] psum_q [$];
  logic [63:0] exp_q [$];    // expected output beats
  logic [31:0] rdata;
  logic        err;
  int done_cnt = 0, cmd_cnt = 0, err_cnt = 0, check_cnt = 0, test_cnt = 0, test_err = 0;

  accum_top i_accum_top (.*);

  initial begin
    clk_state = 1'b0;
    forever #4 clk_state = ~clk_state;
  end

  // ============================================================
  // reference and helpers
  // ============================================================
  function automatic logic [7:0] normquant_ref(input logic signed [31:0] acc,
                                               input logic [7:0] scale, input logic [4:0] shift);
    longint prod;
    prod = (longint'(acc) * longint'(scale)) >>> shift;
    if (prod > 127) return 8'h7f;
    else if (prod < -128) return 8'h80;
    else return prod[7:0];
  endfunction

  task automatic check_value(input string what, input logic [63:0] got, input logic [63:0] exp);
    check_cnt++;
    if (got !== exp) begin
      err_cnt++;
      $display("[ERROR] %0t: %s, got %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic apb_access(input logic wr, input logic [7:0] addr, input logic [31:0] data);
    @(posedge clk_state);
    psel_i   <= 1'b1;  // setup phase
    penable_i <= 1'b0;
    pwrite_i <= wr;
    paddr_i  <= addr;
    pwdata_i <= data;
    @(posedge clk_state);
    penable_i <= 1'b1;
    @(negedge clk_state);
    rdata = prdata_o;
    err   = pslverr_o;
    @(posedge clk_state);
    psel_i    <= 1'b0;
    penable_i <= 1'b0;
  endtask

  task automatic issue_cmd(input logic [2:0] code);
    apb_access(1'b1, accum_pkg::REG_CMD, 32'(code));
    check_value("command accepted", err, 0);
    cmd_cnt++;
  endtask

  task automatic wait_done();
    while (done_cnt < cmd_cnt) @(negedge clk_state);
  endtask

  task automatic queue_psums(input int n);
    logic [31:0] p;
    for (int i = 0; i < n; i++) begin
      p = $urandom;
      psum_q.push_back(p);
      ref_acc[i % 8] = ref_acc[i % 8] + p;  // round robin from address 0
    end
  endtask

  task automatic accumulate(input int n);
    apb_access(1'b1, accum_pkg::REG_ACCUM_LEN, n);
    queue_psums(n);
    issue_cmd(accum_pkg::CMD_ACCUM);
    wait_done();
  endtask

  task automatic streamout(input logic mode);
    logic [63:0] w;
    apb_access(1'b1, accum_pkg::REG_MODE, 32'(mode));
    if (mode == accum_pkg::MODE_32B) begin
      for (int b = 0; b < 4; b++) exp_q.push_back({ref_acc[2*b+1], ref_acc[2*b]});
    end else begin
      for (int i = 0; i < 8; i++) w[8*i +: 8] = ref_acc[i][7:0];
      exp_q.push_back(w);
    end
    issue_cmd(accum_pkg::CMD_STREAMOUT);
    wait_done();
    check_value("beats still expected", exp_q.size(), 0);
  endtask

  task automatic end_test(input string name);
    test_cnt++;
    $display("test %0d %s: %s", test_cnt, name, (err_cnt == test_err) ? "ok" : "mismatch");
    test_err = err_cnt;
  endtask

  // ============================================================
  // stream driver, sink, compare and done counter
  // ============================================================
  initial begin
    logic taken;
    forever begin
      @(negedge clk_state);
      taken = psum_valid_i && psum_ready_o;
      @(posedge clk_state);
      if (taken) void'(psum_q.pop_front());
      if (taken || !psum_valid_i) begin  // hold an offered value until taken
        if (psum_q.size() > 0 && $urandom_range(3) != 0) begin
          psum_valid_i <= 1'b1;
          psum_data_i  <= psum_q[0];
        end else begin
          psum_valid_i <= 1'b0;
        end
      end
    end
  end

  always @(posedge clk_state) out_ready_i <= ($urandom_range(3) != 0);

  always @(negedge clk_state) begin
    if (out_valid_o && out_ready_i) begin
      if (exp_q.size() == 0) begin
        err_cnt++;
        $display("unexpected output beat at %0t", $time);
      end else begin
        check_value("output beat", out_data_o, exp_q.pop_front());
      end
    end
    if (done_o) done_cnt++;
  end

  initial begin
    #TimeLimit;
    $display("timeout: the DUT did not finish the tests in time");
    $display("*** FAILED ***");
    $finish;
  end

  // ============================================================
  // tests
  // ============================================================
  initial begin
    logic [7:0] scale, q;
    logic [4:0] shift;
    void'($urandom(2375));
    rst_ni = 1'b0;
    psel_i = 1'b0;
    penable_i = 1'b0;
    pwrite_i = 1'b0;
    paddr_i = '0;
    pwdata_i = '0;
    psum_valid_i = 1'b0;
    psum_data_i = '0;
    out_ready_i = 1'b0;
    foreach (ref_acc[i]) ref_acc[i] = '0;
    repeat (5) @(posedge clk_state);
    rst_ni <= 1'b1;

    accumulate(8);  // nonzero bank for the clear to remove
    issue_cmd(accum_pkg::CMD_CLEAR);
    wait_done();
    foreach (ref_acc[i]) ref_acc[i] = '0;
    apb_access(1'b0, accum_pkg::REG_STATUS, 0);
    check_value("status busy", rdata[0], 0);
    streamout(accum_pkg::MODE_32B);
    end_test("clear");

    accumulate(20);
    streamout(accum_pkg::MODE_32B);
    end_test("accumulate");

    scale = $urandom_range(255, 1);
    shift = $urandom_range(31, 20);  // mix of saturated and in-range results
    apb_access(1'b1, accum_pkg::REG_SCALE, 32'(scale));
    apb_access(1'b1, accum_pkg::REG_SHIFT, 32'(shift));
    issue_cmd(accum_pkg::CMD_NORMQUANT);
    wait_done();
    foreach (ref_acc[i]) begin
      q = normquant_ref(ref_acc[i], scale, shift);
      ref_acc[i] = {{24{q[7]}}, q};
    end
    streamout(accum_pkg::MODE_8B);
    end_test("normquant");

    accumulate(12);
    streamout(accum_pkg::MODE_32B);
    end_test("accumulate again");

    // accumulate stalls with no partial sums queued, so the bank stays busy
    apb_access(1'b1, accum_pkg::REG_ACCUM_LEN, 4);
    issue_cmd(accum_pkg::CMD_ACCUM);
    apb_access(1'b0, accum_pkg::REG_STATUS, 0);
    check_value("status while busy", rdata[0], 1);
    apb_access(1'b1, accum_pkg::REG_CMD, 32'(accum_pkg::CMD_CLEAR));
    check_value("command while busy error", err, 1);
    apb_access(1'b0, 8'h18, 0);
    check_value("unmapped address error", err, 1);
    queue_psums(4);
    wait_done();
    streamout(accum_pkg::MODE_32B);
    end_test("bus errors");

    repeat (4) @(negedge clk_state);
    check_value("done pulses", done_cnt, cmd_cnt);
    end_test("done count");

    err_cnt += i_accum_top.i_accum_asserts.fail_cnt;
    $display("tests %0d, checks %0d, errors %0d", test_cnt, check_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule
